//--- addr_router.sv
// Address decoder between the ingress FIFO and the two targets.
// Each request is matched against base and mask of every region and sent to one target.
// Its route goes into the route queue at the same edge, so responses can be put back in order.
// Unmapped requests get a NONE route and reach no target.
`include "soc_settings.svh"

module addr_router import soc_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n_i,
    input  bus_req_t in_req_i,
    input  logic     in_empty_i,
    output logic     in_pop_o,
    input  logic     route_full_i,
    output logic     route_push_o,
    output route_t   route_o,
    output logic     mem_stb_o,
    output logic     periph_stb_o,
    output bus_req_t tgt_req_o
);

    logic hit_mem;
    logic hit_periph;
    logic issue;

    // Same base/mask match as the crossbar
    assign hit_mem    = ((in_req_i.addr & `SOC_MEM_MASK) == `SOC_MEM_BASE);
    assign hit_periph = ((in_req_i.addr & `SOC_PERIPH_MASK) == `SOC_PERIPH_BASE);

    // Stall while the route queue is full
    assign issue        = !in_empty_i && !route_full_i;
    assign in_pop_o     = issue;
    assign route_push_o = issue;

    always_comb
    begin
        if (hit_mem)
            route_o.tgt = ROUTE_MEM;
        else if (hit_periph)
            route_o.tgt = ROUTE_PERIPH;
        else
            route_o.tgt = ROUTE_NONE;
    end

    always_ff @(posedge sys_clk)
    begin
        if (!rst_n_i)
        begin
            mem_stb_o    <= 1'b0;
            periph_stb_o <= 1'b0;
        end
        else
        begin
            mem_stb_o    <= issue && hit_mem;
            periph_stb_o <= issue && hit_periph;
        end
    end

    // Payload only, qualified by the strobes
    always_ff @(posedge sys_clk)
    begin
        if (issue)
            tgt_req_o <= in_req_i;
    end

    // One route entry per request means at most one target answers it
    a_one_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        $onehot0({mem_stb_o, periph_stb_o}));

endmodule

//--- credit_fifo.sv
// Synchronous register-array FIFO for any payload type.
// The head is visible on data_o while not empty, and pop_i removes it.
// credit_o pulses one cycle after each pop so a sender can count free slots.
module credit_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic sys_clk,
    input  logic rst_n_i,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output T     data_o,
    output logic empty_o,
    output logic full_o,
    output logic credit_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem_q [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == CW'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem_q[rd_ptr]; // Head shown combinationally

    always_ff @(posedge sys_clk)
    begin
        if (do_push)
            mem_q[wr_ptr] <= data_i;
    end

    always_ff @(posedge sys_clk)
    begin
        if (!rst_n_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count    <= count + CW'(do_push) - CW'(do_pop);
            credit_o <= do_pop; // One slot freed
        end
    end

    // The sender's credit count must keep it from overrunning us
    a_no_push_full: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(push_i && full_o));
    a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(pop_i && empty_o));

endmodule

//--- data_mem.sv
// Word-wide data memory behind the router.
// Takes one strobe per cycle and answers exactly one cycle later.
// Writes honour the byte selects and answer with zero data.
// There is no error case here.
`include "soc_settings.svh"

module data_mem import soc_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  bus_req_t req_i,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o
);

    localparam int IW = $clog2(`SOC_MEM_WORDS);

    logic [`SOC_DW-1:0] mem_q [`SOC_MEM_WORDS];
    logic [IW-1:0]      idx;

    assign idx = req_i.addr[IW-1:0]; // Region mask guarantees the upper bits

    always_ff @(posedge sys_clk)
    begin
        if (stb_i && req_i.we)
        begin
            for (int b = 0; b < `SOC_DW/8; b++)
            begin
                if (req_i.sel[b])
                    mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (stb_i)
        begin
            rsp_o.rdata <= req_i.we ? '0 : mem_q[idx]; // Old word on read
            rsp_o.err   <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (!rst_n_i)
            rsp_valid_o <= 1'b0;
        else
            rsp_valid_o <= stb_i;
    end

endmodule

//--- list.f
+incdir+.
soc_pkg.sv
credit_fifo.sv
addr_router.sv
data_mem.sv
periph_regs.sv
rsp_merger.sv
soc_fabric_top.sv
tb_soc_fabric.sv

//--- periph_regs.sv
// Shared peripheral register bus with two GPIO outputs, a scratch and an ID register.
// Accepts one strobe per cycle, the response leaves two cycles later.
// Reads of unused offsets return zero and writes answer with zero data.
`include "soc_settings.svh"

module periph_regs import soc_pkg::*; (
    input  logic                    sys_clk,
    input  logic                    rst_n_i,
    input  logic                    stb_i,
    input  bus_req_t                req_i,
    output logic                    rsp_valid_o,
    output bus_rsp_t                rsp_o,
    output logic [`SOC_GPIO0_W-1:0] gpio0_o,
    output logic [`SOC_GPIO1_W-1:0] gpio1_o
);

    localparam int OFS_W = 4; // 64-byte window holds 16 words

    logic [OFS_W-1:0]   ofs;
    logic [`SOC_DW-1:0] rd_data;
    logic [`SOC_DW-1:0] scratch_q;
    logic               s1_valid;
    bus_rsp_t           s1_rsp;

    assign ofs = req_i.addr[OFS_W-1:0];

    always_comb
    begin
        case (ofs)
            `SOC_GPIO0_OFS:   rd_data = `SOC_DW'(gpio0_o);
            `SOC_GPIO1_OFS:   rd_data = `SOC_DW'(gpio1_o);
            `SOC_SCRATCH_OFS: rd_data = scratch_q;
            `SOC_ID_OFS:      rd_data = `SOC_ID_VALUE;
            default:          rd_data = '0;
        endcase
    end

    always_ff @(posedge sys_clk)
    begin
        if (!rst_n_i)
        begin
            gpio0_o   <= '0;
            gpio1_o   <= '0;
            scratch_q <= '0;
        end
        else if (stb_i && req_i.we)
        begin
            case (ofs)
                `SOC_GPIO0_OFS:
                    if (req_i.sel[0])
                        gpio0_o <= req_i.wdata[`SOC_GPIO0_W-1:0];
                `SOC_GPIO1_OFS:
                    if (req_i.sel[0])
                        gpio1_o <= req_i.wdata[`SOC_GPIO1_W-1:0];
                `SOC_SCRATCH_OFS:
                    for (int b = 0; b < `SOC_DW/8; b++)
                    begin
                        if (req_i.sel[b])
                            scratch_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                default: ; // ID and holes ignore writes
            endcase
        end
    end

    // Two response stages
    always_ff @(posedge sys_clk)
    begin
        if (stb_i)
        begin
            s1_rsp.rdata <= req_i.we ? '0 : rd_data;
            s1_rsp.err   <= 1'b0;
        end
        if (s1_valid)
            rsp_o <= s1_rsp;
    end

    always_ff @(posedge sys_clk)
    begin
        if (!rst_n_i)
        begin
            s1_valid    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end
        else
        begin
            s1_valid    <= stb_i;
            rsp_valid_o <= s1_valid;
        end
    end

endmodule

//--- rsp_merger.sv
// Puts target responses back into request order.
// Each target fills its own FIFO; the head of the route queue says which one answers next.
// A NONE route is answered at once with an error and zero data.
// Output is paced by response credits returned by the master.
`include "soc_settings.svh"

module rsp_merger import soc_pkg::*; (
    input  logic     sys_clk,
    input  logic     rst_n_i,
    input  route_t   route_i,
    input  logic     route_empty_i,
    output logic     route_pop_o,
    input  logic     mem_valid_i,
    input  bus_rsp_t mem_rsp_i,
    input  logic     periph_valid_i,
    input  bus_rsp_t periph_rsp_i,
    input  logic     rsp_credit_i,
    output logic     rsp_valid_o,
    output bus_rsp_t rsp_o
);

    localparam int CW = $clog2(`SOC_RSP_CREDITS + 1);

    logic          mem_empty;
    logic          mem_full;
    bus_rsp_t      mem_head;
    logic          periph_empty;
    logic          periph_full;
    bus_rsp_t      periph_head;
    logic          head_ready;
    logic          emit;
    bus_rsp_t      head_rsp;
    logic [CW-1:0] credit_cnt;

    // Route queue depth bounds what can land here, so no back-pressure
    credit_fifo #(.T(bus_rsp_t), .DEPTH(`SOC_ORDER_DEPTH)) mem_fifo_inst (
        .sys_clk  (sys_clk),
        .rst_n_i  (rst_n_i),
        .push_i   (mem_valid_i),
        .data_i   (mem_rsp_i),
        .pop_i    (emit && route_i.tgt == ROUTE_MEM),
        .data_o   (mem_head),
        .empty_o  (mem_empty),
        .full_o   (mem_full),
        .credit_o ()
    );

    credit_fifo #(.T(bus_rsp_t), .DEPTH(`SOC_ORDER_DEPTH)) periph_fifo_inst (
        .sys_clk  (sys_clk),
        .rst_n_i  (rst_n_i),
        .push_i   (periph_valid_i),
        .data_i   (periph_rsp_i),
        .pop_i    (emit && route_i.tgt == ROUTE_PERIPH),
        .data_o   (periph_head),
        .empty_o  (periph_empty),
        .full_o   (periph_full),
        .credit_o ()
    );

    always_comb
    begin
        head_ready = 1'b0;
        head_rsp   = '{rdata: '0, err: 1'b1}; // Unmapped answer
        case (route_i.tgt)
            ROUTE_MEM:
            begin
                head_ready = !mem_empty;
                head_rsp   = mem_head;
            end
            ROUTE_PERIPH:
            begin
                head_ready = !periph_empty;
                head_rsp   = periph_head;
            end
            default: head_ready = 1'b1;
        endcase
    end

    assign emit        = !route_empty_i && head_ready && (credit_cnt != '0);
    assign route_pop_o = emit;

    always_ff @(posedge sys_clk)
    begin
        if (!rst_n_i)
        begin
            rsp_valid_o <= 1'b0;
            credit_cnt  <= CW'(`SOC_RSP_CREDITS);
        end
        else
        begin
            rsp_valid_o <= emit;
            credit_cnt  <= credit_cnt + CW'(rsp_credit_i) - CW'(emit);
        end
    end

    always_ff @(posedge sys_clk)
    begin
        if (emit)
            rsp_o <= head_rsp;
    end

    // Master may only hand back credits it was given
    a_credit_max: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        credit_cnt <= CW'(`SOC_RSP_CREDITS));

    // Order queue must keep both response FIFOs from filling past their routes
    a_rsp_no_overflow: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(mem_valid_i && mem_full) && !(periph_valid_i && periph_full));

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator, then judge the simulation log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_soc_fabric -f list.f \
    -o sim_soc_fabric > build.log 2>&1 &&
./obj_dir/sim_soc_fabric > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- soc_fabric_top.sv
// Top of the reduced SoC bus fabric.
// One credit-based master port feeds an ingress FIFO, the router and two targets.
// Responses come back in request order under response credits.
`include "soc_settings.svh"

module soc_fabric_top import soc_pkg::*; (
    input  logic                    sys_clk,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    input  bus_req_t                req_i,
    output logic                    req_credit_o,
    input  logic                    rsp_credit_i,
    output logic                    rsp_valid_o,
    output bus_rsp_t                rsp_o,
    output logic [`SOC_GPIO0_W-1:0] gpio0_o,
    output logic [`SOC_GPIO1_W-1:0] gpio1_o
);

    bus_req_t in_head;
    logic     in_empty;
    logic     in_pop;
    route_t   route_new;
    route_t   route_head;
    logic     route_push;
    logic     route_pop;
    logic     route_empty;
    logic     route_full;
    logic     mem_stb;
    logic     periph_stb;
    bus_req_t tgt_req;
    logic     mem_valid;
    bus_rsp_t mem_rsp;
    logic     periph_valid;
    bus_rsp_t periph_rsp;

    credit_fifo #(.T(bus_req_t), .DEPTH(`SOC_REQ_DEPTH)) ingress_fifo_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .push_i(req_valid_i), .data_i(req_i),
        .pop_i(in_pop), .data_o(in_head),
        .empty_o(in_empty), .full_o(),
        .credit_o(req_credit_o)
    );

    credit_fifo #(.T(route_t), .DEPTH(`SOC_ORDER_DEPTH)) route_fifo_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .push_i(route_push), .data_i(route_new),
        .pop_i(route_pop), .data_o(route_head),
        .empty_o(route_empty), .full_o(route_full),
        .credit_o()
    );

    addr_router addr_router_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .in_req_i(in_head), .in_empty_i(in_empty), .in_pop_o(in_pop),
        .route_full_i(route_full), .route_push_o(route_push), .route_o(route_new),
        .mem_stb_o(mem_stb), .periph_stb_o(periph_stb), .tgt_req_o(tgt_req)
    );

    data_mem data_mem_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .stb_i(mem_stb), .req_i(tgt_req),
        .rsp_valid_o(mem_valid), .rsp_o(mem_rsp)
    );

    periph_regs periph_regs_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .stb_i(periph_stb), .req_i(tgt_req),
        .rsp_valid_o(periph_valid), .rsp_o(periph_rsp),
        .gpio0_o(gpio0_o), .gpio1_o(gpio1_o)
    );

    rsp_merger rsp_merger_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .route_i(route_head), .route_empty_i(route_empty), .route_pop_o(route_pop),
        .mem_valid_i(mem_valid), .mem_rsp_i(mem_rsp),
        .periph_valid_i(periph_valid), .periph_rsp_i(periph_rsp),
        .rsp_credit_i(rsp_credit_i), .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o)
    );

endmodule

//--- soc_pkg.sv
// Bus types shared by the fabric RTL and its testbench.
// A request carries one word access, a response returns read data and an error flag.
// The route type tags each accepted request with the target that answers it.
`include "soc_settings.svh"

package soc_pkg;

    // One word access from the master
    typedef struct packed {
        logic [`SOC_AW-1:0]   addr;  // Word address
        logic [`SOC_DW-1:0]   wdata;
        logic [`SOC_DW/8-1:0] sel;   // Byte selects
        logic                 we;
    } bus_req_t;

    // Answer to one request
    typedef struct packed {
        logic [`SOC_DW-1:0] rdata;
        logic               err;
    } bus_rsp_t;

    // Which target answers a request
    typedef enum logic [1:0] {
        ROUTE_MEM    = 2'd0,
        ROUTE_PERIPH = 2'd1,
        ROUTE_NONE   = 2'd2  // Unmapped, answered with an error
    } route_e;

    // Entry of the route queue
    typedef struct packed {
        route_e tgt;
    } route_t;

endpackage

//--- soc_settings.svh
// Widths, depths and address map of the SoC bus fabric.
// Include this in every file that needs a size, a base address or a register offset.
// Bases and masks are word addresses, which are byte addresses shifted right by two.
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

`define SOC_AW          28 // Word address width
`define SOC_DW          32

`define SOC_REQ_DEPTH   4 // Ingress FIFO, also the master's initial credits
`define SOC_ORDER_DEPTH 4 // Bounds the requests in flight
`define SOC_RSP_CREDITS 2

`define SOC_MEM_WORDS   1024

// Data memory, byte 0x00000000 with 4 KB
`define SOC_MEM_BASE    28'h0000000
`define SOC_MEM_MASK    28'hffffc00

// Peripheral window, byte 0x10000000 with 64 B
`define SOC_PERIPH_BASE 28'h4000000
`define SOC_PERIPH_MASK 28'hffffff0

// Word offsets inside the peripheral window
`define SOC_GPIO0_OFS   4'd0
`define SOC_GPIO1_OFS   4'd4
`define SOC_SCRATCH_OFS 4'd8
`define SOC_ID_OFS      4'd12

`define SOC_ID_VALUE    32'h50C0FAB1
`define SOC_GPIO0_W     8
`define SOC_GPIO1_W     4

`endif

//--- tb_soc_fabric.sv
// Testbench for the SoC bus fabric top level.
// Sends credit-paced requests, predicts each answer with a reference model of memory and
// registers, and checks the responses in request order. Run it through list.f.
`include "soc_settings.svh"

module tb_soc_fabric import soc_pkg::*; ();

    localparam int MAX_REQS       = 140;
    localparam int TIMEOUT_CYCLES = 400 + 25 * MAX_REQS; // Slow path per request plus idle waits
    localparam int IW             = $clog2(`SOC_MEM_WORDS);

    logic                    sys_clk = 1'b0;
    logic                    rst_n_i;
    logic                    req_valid_i;
    bus_req_t                req_i;
    logic                    req_credit_o;
    logic                    rsp_credit_i = 1'b0;
    logic                    rsp_valid_o;
    bus_rsp_t                rsp_o;
    logic [`SOC_GPIO0_W-1:0] gpio0_o;
    logic [`SOC_GPIO1_W-1:0] gpio1_o;

    logic [`SOC_DW-1:0]      model_mem [`SOC_MEM_WORDS];
    logic [`SOC_GPIO0_W-1:0] model_gpio0 = '0;
    logic [`SOC_GPIO1_W-1:0] model_gpio1 = '0;
    logic [`SOC_DW-1:0]      model_scratch = '0;

    bus_rsp_t exp_q [$];
    int       due_q [$];        // Cycles at which response credits go back
    int       delay_tab [256];
    integer   seed = 29247;
    int       cycle_cnt = 0;
    int       req_sent = 0;
    int       req_back = 0;
    int       rsp_seen = 0;
    int       dut_credits = `SOC_RSP_CREDITS;
    logic     hold_credits = 1'b0;
    int       val_errs = 0;
    int       other_errs = 0;

    soc_fabric_top soc_fabric_top_inst (
        .sys_clk(sys_clk), .rst_n_i(rst_n_i),
        .req_valid_i(req_valid_i), .req_i(req_i), .req_credit_o(req_credit_o),
        .rsp_credit_i(rsp_credit_i), .rsp_valid_o(rsp_valid_o), .rsp_o(rsp_o),
        .gpio0_o(gpio0_o), .gpio1_o(gpio1_o)
    );

    always #5 sys_clk = ~sys_clk;

    // Request credits counted like a flop, plus the run limit
    always @(posedge sys_clk)
    begin
        if (rst_n_i && req_credit_o)
            req_back <= req_back + 1;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, %0d responses missing", cycle_cnt, exp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    // Expected answer of one request, applied to the model state in request order
    function automatic bus_rsp_t model_access(input bus_req_t r);
        bus_rsp_t      rsp;
        logic [IW-1:0] idx;
        logic [3:0]    ofs;
        rsp = '0;
        idx = r.addr[IW-1:0];
        ofs = r.addr[3:0];
        if (r.addr < `SOC_AW'(`SOC_MEM_WORDS)) // First 4 KB
        begin
            for (int b = 0; b < `SOC_DW/8; b++)
            begin
                if (r.we && r.sel[b])
                    model_mem[idx][8*b +: 8] = r.wdata[8*b +: 8];
            end
            if (!r.we)
                rsp.rdata = model_mem[idx];
        end
        else if (r.addr >= `SOC_PERIPH_BASE && r.addr < `SOC_PERIPH_BASE + 28'd16)
        begin
            if (r.we && ofs == `SOC_GPIO0_OFS && r.sel[0])
                model_gpio0 = r.wdata[`SOC_GPIO0_W-1:0];
            if (r.we && ofs == `SOC_GPIO1_OFS && r.sel[0])
                model_gpio1 = r.wdata[`SOC_GPIO1_W-1:0];
            for (int b = 0; b < `SOC_DW/8; b++)
            begin
                if (r.we && ofs == `SOC_SCRATCH_OFS && r.sel[b])
                    model_scratch[8*b +: 8] = r.wdata[8*b +: 8];
            end
            if (!r.we && ofs == `SOC_GPIO0_OFS)
                rsp.rdata = `SOC_DW'(model_gpio0);
            else if (!r.we && ofs == `SOC_GPIO1_OFS)
                rsp.rdata = `SOC_DW'(model_gpio1);
            else if (!r.we && ofs == `SOC_SCRATCH_OFS)
                rsp.rdata = model_scratch;
            else if (!r.we && ofs == `SOC_ID_OFS)
                rsp.rdata = `SOC_ID_VALUE;
        end
        else
            rsp.err = 1'b1; // Nobody decodes it
        return rsp;
    endfunction

    function automatic bus_req_t make_req(input logic [`SOC_AW-1:0] addr,
                                          input logic [`SOC_DW-1:0] wdata,
                                          input logic [3:0] sel, input logic we);
        bus_req_t r;
        r.addr  = addr;
        r.wdata = wdata;
        r.sel   = sel;
        r.we    = we;
        return r;
    endfunction

    function automatic logic [`SOC_DW-1:0] fill_word(input logic [`SOC_AW-1:0] addr);
        return (`SOC_DW'(addr) * 32'h9E3779B1) ^ 32'h5A5A5A5A;
    endfunction

    // Mix of memory, peripheral and unmapped accesses
    function automatic bus_req_t rand_req();
        int                 kind;
        logic [3:0]         word;
        logic [`SOC_DW-1:0] data;
        logic [3:0]         sel;
        kind = int'($unsigned($random(seed)) % 10);
        word = 4'($random(seed));
        data = $random(seed);
        sel  = 4'($random(seed));
        if (kind < 6)
            return make_req(`SOC_AW'(word), data, sel, kind < 3); // Preloaded words only
        else if (kind < 9)
            return make_req(`SOC_PERIPH_BASE + `SOC_AW'(word), data, sel, kind == 6);
        return make_req(28'h8000000 + `SOC_AW'(word), data, sel, word[0]);
    endfunction

    function automatic int credits_avail();
        return `SOC_REQ_DEPTH + req_back - req_sent;
    endfunction

    task automatic report_value(input string name, input logic [`SOC_DW:0] got,
                                input logic [`SOC_DW:0] exp);
        val_errs++;
        $display("[ERROR] %s = %h, expected %h", name, got, exp);
    endtask

    task automatic report_other(input string what);
        other_errs++;
        $display("%s", what);
    endtask

    task automatic send_req(input bus_req_t r);
        while (credits_avail() <= 0)
            @(negedge sys_clk);
        req_valid_i = 1'b1;
        req_i       = r;
        req_sent++;
        exp_q.push_back(model_access(r));
        @(negedge sys_clk);
        req_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || due_q.size() != 0)
            @(negedge sys_clk);
        repeat (2) @(negedge sys_clk);
    endtask

    task automatic check_gpio();
        assert (gpio0_o == model_gpio0)
        else report_value("gpio0_o", 33'(gpio0_o), 33'(model_gpio0));
        assert (gpio1_o == model_gpio1)
        else report_value("gpio1_o", 33'(gpio1_o), 33'(model_gpio1));
    endtask

    // Response side compares in order and hands credits back after a random delay
    always @(negedge sys_clk)
    begin
        bus_rsp_t exp;
        rsp_credit_i = 1'b0;
        if (!rst_n_i)
            dut_credits = `SOC_RSP_CREDITS;
        else
        begin
            if (rsp_valid_o)
            begin
                assert (dut_credits > 0) else report_other("Response sent without a credit");
                dut_credits--;
                assert (exp_q.size() > 0) else report_other("Response with no request pending");
                if (exp_q.size() > 0)
                begin
                    exp = exp_q.pop_front();
                    assert (rsp_o == exp) else report_value("rsp_o", rsp_o, exp);
                end
                due_q.push_back(cycle_cnt + 1 + delay_tab[rsp_seen % 256]);
                rsp_seen++;
            end
            if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle_cnt)
            begin
                void'(due_q.pop_front());
                rsp_credit_i = 1'b1;
                dut_credits++;
            end
        end
    end

    initial
    begin
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        for (int i = 0; i < 256; i++)
            delay_tab[i] = $random(seed) & 7;
        repeat (8) @(negedge sys_clk);
        rst_n_i = 1'b1;

        repeat (10) // Quiet after reset
        begin
            @(negedge sys_clk);
            assert (!rsp_valid_o && !req_credit_o) else report_other("Activity while idle");
            check_gpio();
        end

        for (int w = 0; w < 16; w++)
            send_req(make_req(`SOC_AW'(w), fill_word(`SOC_AW'(w)), 4'hF, 1'b1));
        send_req(make_req(`SOC_AW'(`SOC_MEM_WORDS - 1), 32'h01234567, 4'hF, 1'b1));
        for (int w = 0; w < 8; w++)
            send_req(make_req(`SOC_AW'(w), 32'hC3A5E100 ^ `SOC_DW'(w), 4'(w + 5), 1'b1));
        send_req(make_req(`SOC_AW'(`SOC_MEM_WORDS - 1), 32'hFFFFFFFF, 4'b1010, 1'b1));
        for (int w = 0; w < 16; w++)
            send_req(make_req(`SOC_AW'(w), '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_AW'(`SOC_MEM_WORDS - 1), '0, 4'hF, 1'b0));
        drain();

        send_req(make_req(`SOC_PERIPH_BASE + `SOC_GPIO0_OFS, 32'hDEADBE5A, 4'h1, 1'b1));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_GPIO1_OFS, 32'h0000000C, 4'h1, 1'b1));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_GPIO0_OFS, 32'h000000FF, 4'hE, 1'b1));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_GPIO0_OFS, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_GPIO1_OFS, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_SCRATCH_OFS, 32'h12345678, 4'hF, 1'b1));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_SCRATCH_OFS, 32'h00AB0000, 4'h4, 1'b1));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_SCRATCH_OFS, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_ID_OFS, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_ID_OFS, 32'h0, 4'hF, 1'b1));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_ID_OFS, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + 28'd3, '0, 4'hF, 1'b0)); // Hole in the map
        drain();
        check_gpio();

        send_req(make_req(28'h0000400, 32'hFFFFFFFF, 4'hF, 1'b1)); // Just past the memory
        send_req(make_req(28'h0000400, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + 28'h10, 32'hFFFFFFFF, 4'hF, 1'b1));
        send_req(make_req(28'hFFFFFFF, 32'h0, 4'hF, 1'b1));
        send_req(make_req(28'h8000000, '0, 4'h0, 1'b0));
        send_req(make_req(28'h0000000, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_SCRATCH_OFS, '0, 4'hF, 1'b0));
        send_req(make_req(`SOC_PERIPH_BASE + `SOC_GPIO0_OFS, '0, 4'hF, 1'b0));
        drain();
        check_gpio();

        repeat (40)
            send_req(rand_req());
        drain();
        check_gpio();

        // Withhold response credits until the whole path backs up
        hold_credits <= 1'b1;
        repeat (30)
        begin
            if (credits_avail() > 0)
                send_req(rand_req());
            else
                @(negedge sys_clk);
        end
        repeat (10) @(negedge sys_clk);
        assert (credits_avail() == 0) else report_other("Master kept request credits");
        repeat (16)
        begin
            @(negedge sys_clk);
            assert (!req_credit_o) else report_other("Request credit while responses held");
        end
        hold_credits <= 1'b0;
        drain();
        check_gpio();

        assert (rsp_seen == req_sent) else report_other("Response count differs from requests");
        $display("Requests %0d, responses %0d, value errors %0d, other errors %0d",
                 req_sent, rsp_seen, val_errs, other_errs);
        if (val_errs + other_errs == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
